/* rtl/mhp_pkg.sv */
package mhp_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  addr_t;
  typedef logic [15:0] node_addr_t;
  typedef logic [7:0]  len_t;
  typedef logic [15:0] cksum_t;

  //////////////////////////////
  // frame constants
  //////////////////////////////
  // idle cycles that close a received frame
  localparam int   IDLE_LIMIT   = 62;
  localparam int   HEADER_LEN   = 7;
  localparam len_t TX_FRAME_LEN = 8'd50;

  // command field is the low 5 bits of the type byte
  localparam logic [4:0] CMD_PING     = 5'h01;
  localparam logic [4:0] CMD_ADDR_REQ = 5'h04;
  localparam int         ACK_BIT      = 4;

  // full reply lengths, checksum included
  localparam len_t PING_REPLY_LEN  = 8'd10;
  localparam len_t GRANT_REPLY_LEN = 8'd11;

  typedef enum logic [1:0] {
    REPLY_NONE,
    REPLY_PING,
    REPLY_GRANT
  } reply_kind_t;

  // templates without the two checksum bytes
  // bytes 0..3 get replaced by the swapped addresses
  localparam byte_t [0:7] PING_TMPL =
    {8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h01, 8'h81, 8'h00};
  localparam byte_t [0:8] GRANT_TMPL =
    {8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h02, 8'h92, 8'h01, 8'h20};

endpackage

/* rtl/ram_if.sv */
`timescale 1ns/1ps

interface ram_if;
  logic           en;
  logic           we;
  mhp_pkg::addr_t addr;
  mhp_pkg::byte_t wdata;
  // valid one cycle after en
  mhp_pkg::byte_t rdata;

  // buffer user, holds everything at zero while idle
  modport master (output en, we, addr, wdata, input rdata);

  // buffer side
  modport ram (input en, we, addr, wdata, output rdata);
endinterface

/* rtl/frame_ram.sv */
`timescale 1ns/1ps

module frame_ram import mhp_pkg::*; (
  input logic i_clk,
  ram_if.ram  rx_port,
  ram_if.ram  hdr_port,
  ram_if.ram  bld_port,
  ram_if.ram  cks_port,
  ram_if.ram  tx_port
);

  byte_t mem [0:255];
  logic  en;
  logic  we;
  addr_t addr;
  byte_t wdata;
  byte_t rdata_q;

  // only one user is active at a time, idle users sit at zero
  assign en    = rx_port.en | hdr_port.en | bld_port.en | cks_port.en | tx_port.en;
  assign we    = rx_port.we | hdr_port.we | bld_port.we | cks_port.we | tx_port.we;
  assign addr  = rx_port.addr | hdr_port.addr | bld_port.addr | cks_port.addr | tx_port.addr;
  assign wdata = rx_port.wdata | hdr_port.wdata | bld_port.wdata | cks_port.wdata
               | tx_port.wdata;

  always_ff @(posedge i_clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata_q <= mem[addr];
    end
  end

  assign rx_port.rdata  = rdata_q;
  assign hdr_port.rdata = rdata_q;
  assign bld_port.rdata = rdata_q;
  assign cks_port.rdata = rdata_q;
  assign tx_port.rdata  = rdata_q;

endmodule

/* rtl/frame_receiver.sv */
`timescale 1ns/1ps

module frame_receiver import mhp_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_req,
  output logic  o_ack,
  input  byte_t i_rdata,
  input  logic  i_rready,
  output logic  o_rreq,
  output len_t  o_len,
  ram_if.master mem
);

  typedef enum logic [2:0] {RX_IDLE, RX_POLL, RX_REQ, RX_LOAD, RX_ACK} rx_state_t;

  rx_state_t  state;
  addr_t      wr_addr;
  logic       started;
  logic [5:0] idle_cnt;
  logic       wr_cyc;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= RX_IDLE;
      wr_addr  <= '0;
      started  <= 1'b0;
      idle_cnt <= '0;
      o_len    <= '0;
    end else begin
      case (state)
        RX_IDLE: begin
          if (i_req) begin
            wr_addr  <= '0;
            started  <= 1'b0;
            idle_cnt <= '0;
            state    <= RX_POLL;
          end
        end
        RX_POLL: begin
          if (i_rready) begin
            state <= RX_REQ;
          end else if (started) begin
            // frame ends after a run of empty cycles
            if (idle_cnt == 6'(IDLE_LIMIT - 1)) begin
              o_len <= wr_addr;
              state <= RX_ACK;
            end else begin
              idle_cnt <= idle_cnt + 6'd1;
            end
          end
        end
        RX_REQ: state <= RX_LOAD;
        RX_LOAD: begin
          wr_addr  <= wr_addr + 8'd1;
          started  <= 1'b1;
          idle_cnt <= '0;
          state    <= RX_POLL;
        end
        RX_ACK: begin
          if (!i_req) begin
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // fifo byte is on i_rdata the cycle after the rreq pulse
  assign wr_cyc    = (state == RX_LOAD);
  assign mem.en    = wr_cyc;
  assign mem.we    = wr_cyc;
  assign mem.addr  = wr_cyc ? wr_addr : '0;
  assign mem.wdata = wr_cyc ? i_rdata : '0;

  assign o_rreq = (state == RX_REQ);
  assign o_ack  = (state == RX_ACK);

endmodule

/* rtl/header_reader.sv */
`timescale 1ns/1ps

module header_reader import mhp_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_req,
  output logic       o_ack,
  output node_addr_t o_src,
  output node_addr_t o_dst,
  output byte_t      o_type,
  ram_if.master      mem
);

  typedef enum logic [1:0] {HD_IDLE, HD_ADDR, HD_LOAD, HD_ACK} hd_state_t;

  hd_state_t  state;
  logic [2:0] idx;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= HD_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        HD_IDLE: begin
          if (i_req) begin
            idx   <= '0;
            state <= HD_ADDR;
          end
        end
        HD_ADDR: state <= HD_LOAD;
        HD_LOAD: begin
          if (idx == 3'(HEADER_LEN - 1)) begin
            state <= HD_ACK;
          end else begin
            idx   <= idx + 3'd1;
            state <= HD_ADDR;
          end
        end
        HD_ACK: begin
          if (!i_req) begin
            state <= HD_IDLE;
          end
        end
        default: state <= HD_IDLE;
      endcase
    end
  end

  // big-endian fields, bytes 4 and 5 hold the size
  always_ff @(posedge i_clk) begin
    if (state == HD_LOAD) begin
      case (idx)
        3'd0: o_src[15:8] <= mem.rdata;
        3'd1: o_src[7:0]  <= mem.rdata;
        3'd2: o_dst[15:8] <= mem.rdata;
        3'd3: o_dst[7:0]  <= mem.rdata;
        3'd6: o_type      <= mem.rdata;
        default: ;
      endcase
    end
  end

  assign mem.en    = (state == HD_ADDR);
  assign mem.we    = 1'b0;
  assign mem.addr  = (state == HD_ADDR) ? addr_t'(idx) : '0;
  assign mem.wdata = '0;

  assign o_ack = (state == HD_ACK);

endmodule

/* rtl/reply_builder.sv */
`timescale 1ns/1ps

module reply_builder import mhp_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_req,
  output logic        o_ack,
  input  reply_kind_t i_kind,
  input  node_addr_t  i_src,
  input  node_addr_t  i_dst,
  ram_if.master       mem
);

  typedef enum logic [1:0] {RB_IDLE, RB_TMPL, RB_SWAP, RB_ACK} rb_state_t;

  rb_state_t  state;
  logic [3:0] idx;
  logic [3:0] tmpl_last;
  byte_t      tmpl_byte;
  byte_t      swap_byte;
  logic       wr_cyc;

  // last template byte sits just before the checksum
  assign tmpl_last = (i_kind == REPLY_GRANT) ? 4'(GRANT_REPLY_LEN - 8'd3)
                                             : 4'(PING_REPLY_LEN - 8'd3);

  always_comb begin
    if (i_kind == REPLY_GRANT) begin
      tmpl_byte = GRANT_TMPL[idx];
    end else begin
      tmpl_byte = PING_TMPL[idx[2:0]];
    end
  end

  // reply goes back to the sender, so dst first
  always_comb begin
    case (idx[1:0])
      2'd0:    swap_byte = i_dst[15:8];
      2'd1:    swap_byte = i_dst[7:0];
      2'd2:    swap_byte = i_src[15:8];
      default: swap_byte = i_src[7:0];
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= RB_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        RB_IDLE: begin
          if (i_req) begin
            idx   <= '0;
            state <= RB_TMPL;
          end
        end
        RB_TMPL: begin
          if (idx == tmpl_last) begin
            idx   <= '0;
            state <= RB_SWAP;
          end else begin
            idx <= idx + 4'd1;
          end
        end
        RB_SWAP: begin
          if (idx == 4'd3) begin
            state <= RB_ACK;
          end else begin
            idx <= idx + 4'd1;
          end
        end
        RB_ACK: begin
          if (!i_req) begin
            state <= RB_IDLE;
          end
        end
        default: state <= RB_IDLE;
      endcase
    end
  end

  // one write per cycle
  assign wr_cyc    = (state == RB_TMPL) || (state == RB_SWAP);
  assign mem.en    = wr_cyc;
  assign mem.we    = wr_cyc;
  assign mem.addr  = wr_cyc ? addr_t'(idx) : '0;
  assign mem.wdata = (state == RB_TMPL) ? tmpl_byte :
                     (state == RB_SWAP) ? swap_byte : '0;

  assign o_ack = (state == RB_ACK);

endmodule

/* rtl/checksum_unit.sv */
`timescale 1ns/1ps

module checksum_unit import mhp_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_req,
  output logic  o_ack,
  input  len_t  i_len,
  ram_if.master mem
);

  typedef enum logic [2:0] {
    CK_IDLE, CK_ADDR, CK_ADD, CK_WHI, CK_WLO, CK_ACK
  } ck_state_t;

  ck_state_t state;
  addr_t     idx;
  addr_t     sum_last;
  cksum_t    sum;

  assign sum_last = i_len - 8'd3;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= CK_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        CK_IDLE: begin
          if (i_req) begin
            idx   <= '0;
            state <= CK_ADDR;
          end
        end
        CK_ADDR: state <= CK_ADD;
        CK_ADD: begin
          if (idx == sum_last) begin
            state <= CK_WHI;
          end else begin
            idx   <= idx + 8'd1;
            state <= CK_ADDR;
          end
        end
        CK_WHI: state <= CK_WLO;
        CK_WLO: state <= CK_ACK;
        CK_ACK: begin
          if (!i_req) begin
            state <= CK_IDLE;
          end
        end
        default: state <= CK_IDLE;
      endcase
    end
  end

  // plain 16-bit sum, wraps
  always_ff @(posedge i_clk) begin
    if (state == CK_IDLE) begin
      sum <= '0;
    end else if (state == CK_ADD) begin
      sum <= sum + cksum_t'(mem.rdata);
    end
  end

  always_comb begin
    mem.en    = 1'b0;
    mem.we    = 1'b0;
    mem.addr  = '0;
    mem.wdata = '0;
    case (state)
      CK_ADDR: begin
        mem.en   = 1'b1;
        mem.addr = idx;
      end
      CK_WHI: begin
        mem.en    = 1'b1;
        mem.we    = 1'b1;
        mem.addr  = i_len - 8'd2;
        mem.wdata = sum[15:8];
      end
      CK_WLO: begin
        mem.en    = 1'b1;
        mem.we    = 1'b1;
        mem.addr  = i_len - 8'd1;
        mem.wdata = sum[7:0];
      end
      default: ;
    endcase
  end

  assign o_ack = (state == CK_ACK);

endmodule

/* rtl/frame_sender.sv */
`timescale 1ns/1ps

module frame_sender import mhp_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_req,
  output logic  o_ack,
  input  len_t  i_len,
  input  logic  i_wready,
  output byte_t o_wdata,
  output logic  o_wvalid,
  ram_if.master mem
);

  typedef enum logic [2:0] {
    TX_IDLE, TX_ADDR, TX_LOAD, TX_WAIT, TX_SEND, TX_ACK
  } tx_state_t;

  tx_state_t state;
  addr_t     pos;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= TX_IDLE;
      pos   <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (i_req) begin
            pos   <= '0;
            state <= TX_ADDR;
          end
        end
        TX_ADDR: state <= TX_LOAD;
        TX_LOAD: state <= TX_WAIT;
        // hold the byte until the tx fifo has room
        TX_WAIT: begin
          if (i_wready) begin
            state <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (pos == TX_FRAME_LEN - 8'd1) begin
            state <= TX_ACK;
          end else begin
            pos   <= pos + 8'd1;
            state <= TX_ADDR;
          end
        end
        TX_ACK: begin
          if (!i_req) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // zero padding past the reply
  always_ff @(posedge i_clk) begin
    if (state == TX_LOAD) begin
      o_wdata <= (pos < i_len) ? mem.rdata : '0;
    end
  end

  assign mem.en    = (state == TX_ADDR);
  assign mem.we    = 1'b0;
  assign mem.addr  = (state == TX_ADDR) ? pos : '0;
  assign mem.wdata = '0;

  assign o_wvalid = (state == TX_SEND);
  assign o_ack    = (state == TX_ACK);

endmodule

/* rtl/message_controller.sv */
`timescale 1ns/1ps

module message_controller import mhp_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  output logic        o_rx_req,
  input  logic        i_rx_ack,
  output logic        o_hdr_req,
  input  logic        i_hdr_ack,
  output logic        o_bld_req,
  input  logic        i_bld_ack,
  output logic        o_cks_req,
  input  logic        i_cks_ack,
  output logic        o_tx_req,
  input  logic        i_tx_ack,
  input  byte_t       i_type,
  output reply_kind_t o_kind,
  output len_t        o_len
);

  typedef enum logic [2:0] {
    MC_START, MC_RECV, MC_HEAD, MC_DECIDE, MC_BUILD, MC_CSUM, MC_SEND
  } mc_state_t;

  mc_state_t   state;
  mc_state_t   phase_next;
  logic        releasing;
  logic        cur_ack;
  reply_kind_t next_kind;
  len_t        next_len;

  //////////////////////////////
  // worker of the current phase
  //////////////////////////////
  always_comb begin
    cur_ack    = 1'b0;
    phase_next = MC_START;
    case (state)
      MC_RECV: begin
        cur_ack    = i_rx_ack;
        phase_next = MC_HEAD;
      end
      MC_HEAD: begin
        cur_ack    = i_hdr_ack;
        phase_next = MC_DECIDE;
      end
      MC_BUILD: begin
        cur_ack    = i_bld_ack;
        phase_next = MC_CSUM;
      end
      MC_CSUM: begin
        cur_ack    = i_cks_ack;
        phase_next = MC_SEND;
      end
      MC_SEND: begin
        cur_ack    = i_tx_ack;
        phase_next = MC_RECV;
      end
      default: ;
    endcase
  end

  // acks are dropped, other commands ignored
  always_comb begin
    next_kind = REPLY_NONE;
    next_len  = '0;
    if (!i_type[ACK_BIT]) begin
      case (i_type[4:0])
        CMD_PING: begin
          next_kind = REPLY_PING;
          next_len  = PING_REPLY_LEN;
        end
        CMD_ADDR_REQ: begin
          next_kind = REPLY_GRANT;
          next_len  = GRANT_REPLY_LEN;
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // sequencer
  //////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= MC_START;
      releasing <= 1'b0;
      o_kind    <= REPLY_NONE;
      o_len     <= '0;
    end else begin
      case (state)
        MC_START: state <= MC_RECV;
        MC_DECIDE: begin
          o_kind <= next_kind;
          o_len  <= next_len;
          state  <= (next_kind == REPLY_NONE) ? MC_RECV : MC_BUILD;
        end
        default: begin
          // four-phase: drop req on ack, move on once ack falls
          if (!releasing) begin
            if (cur_ack) begin
              releasing <= 1'b1;
            end
          end else if (!cur_ack) begin
            releasing <= 1'b0;
            state     <= phase_next;
          end
        end
      endcase
    end
  end

  assign o_rx_req  = (state == MC_RECV)  && !releasing;
  assign o_hdr_req = (state == MC_HEAD)  && !releasing;
  assign o_bld_req = (state == MC_BUILD) && !releasing;
  assign o_cks_req = (state == MC_CSUM)  && !releasing;
  assign o_tx_req  = (state == MC_SEND)  && !releasing;

endmodule

/* rtl/mhp_top.sv */
`timescale 1ns/1ps

module mhp_top import mhp_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  byte_t i_rdata,
  input  logic  i_rready,
  output logic  o_rreq,
  output byte_t o_wdata,
  input  logic  i_wready,
  output logic  o_wvalid
);

  //////////////////////////////
  // buffer ports, one per user
  //////////////////////////////
  ram_if rx_mem ();
  ram_if hdr_mem ();
  ram_if bld_mem ();
  ram_if cks_mem ();
  ram_if tx_mem ();

  logic        rx_req;
  logic        rx_ack;
  logic        hdr_req;
  logic        hdr_ack;
  logic        bld_req;
  logic        bld_ack;
  logic        cks_req;
  logic        cks_ack;
  logic        tx_req;
  logic        tx_ack;
  node_addr_t  src_addr;
  node_addr_t  dst_addr;
  byte_t       msg_type;
  reply_kind_t reply_kind;
  len_t        reply_len;

  frame_ram u_frame_ram (
    .i_clk    (i_clk),
    .rx_port  (rx_mem),
    .hdr_port (hdr_mem),
    .bld_port (bld_mem),
    .cks_port (cks_mem),
    .tx_port  (tx_mem)
  );

  // received length is not needed by the reply path
  frame_receiver u_receiver (
    .i_clk(i_clk), .i_rst(i_rst), .i_req(rx_req), .o_ack(rx_ack),
    .i_rdata(i_rdata), .i_rready(i_rready), .o_rreq(o_rreq),
    .o_len(), .mem(rx_mem)
  );

  header_reader u_header (
    .i_clk(i_clk), .i_rst(i_rst), .i_req(hdr_req), .o_ack(hdr_ack),
    .o_src(src_addr), .o_dst(dst_addr), .o_type(msg_type), .mem(hdr_mem)
  );

  reply_builder u_builder (
    .i_clk(i_clk), .i_rst(i_rst), .i_req(bld_req), .o_ack(bld_ack),
    .i_kind(reply_kind), .i_src(src_addr), .i_dst(dst_addr), .mem(bld_mem)
  );

  checksum_unit u_checksum (
    .i_clk(i_clk), .i_rst(i_rst), .i_req(cks_req), .o_ack(cks_ack),
    .i_len(reply_len), .mem(cks_mem)
  );

  frame_sender u_sender (
    .i_clk(i_clk), .i_rst(i_rst), .i_req(tx_req), .o_ack(tx_ack),
    .i_len(reply_len), .i_wready(i_wready), .o_wdata(o_wdata),
    .o_wvalid(o_wvalid), .mem(tx_mem)
  );

  message_controller u_ctrl (
    .i_clk(i_clk), .i_rst(i_rst),
    .o_rx_req(rx_req),   .i_rx_ack(rx_ack),
    .o_hdr_req(hdr_req), .i_hdr_ack(hdr_ack),
    .o_bld_req(bld_req), .i_bld_ack(bld_ack),
    .o_cks_req(cks_req), .i_cks_ack(cks_ack),
    .o_tx_req(tx_req),   .i_tx_ack(tx_ack),
    .i_type(msg_type), .o_kind(reply_kind), .o_len(reply_len)
  );

endmodule

/* tests/tb_mhp.sv */
`timescale 1ns/1ps

module tb_mhp;

  logic        i_clk;
  logic        i_rst;
  logic [7:0]  i_rdata;
  logic        i_rready;
  logic        o_rreq;
  logic [7:0]  o_wdata;
  logic        i_wready = 1'b1;
  logic        o_wvalid;

  integer      seed;
  logic [7:0]  frame_bytes [0:255];
  int          frame_len;
  logic [15:0] cur_src;
  logic [15:0] cur_dst;
  logic [7:0]  exp_bytes [0:49];
  logic [7:0]  tx_q [$];

  logic        bp_enable = 1'b0;
  logic        bp_now;
  logic [31:0] bp_rand;
  logic        rready_q = 1'b0;
  logic        wready_q = 1'b0;
  logic        rreq_prev = 1'b0;
  logic        wvalid_prev = 1'b0;

  // reply layouts before address swap and checksum
  logic [7:0] ping_tmpl [0:7] =
    '{8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h01, 8'h81, 8'h00};
  logic [7:0] grant_tmpl [0:8] =
    '{8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h02, 8'h92, 8'h01, 8'h20};

  mhp_top uut (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_rdata  (i_rdata),
    .i_rready (i_rready),
    .o_rreq   (o_rreq),
    .o_wdata  (o_wdata),
    .i_wready (i_wready),
    .o_wvalid (o_wvalid)
  );

  initial i_clk = 1'b0;
  always #2 i_clk = ~i_clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  //////////////////////////////
  // handshake monitors
  //////////////////////////////
  always @(posedge i_clk) begin
    rready_q <= i_rready;
    wready_q <= i_wready;
  end

  always @(negedge i_clk) begin
    if (i_rst) begin
      assert (!o_rreq && !o_wvalid)
        else fail_now("o_rreq or o_wvalid was high during reset");
    end
    assert (!o_rreq || rready_q)
      else fail_now("o_rreq pulsed without i_rready sampled high");
    assert (!o_wvalid || wready_q)
      else fail_now("o_wvalid pulsed without i_wready sampled high");
    assert (!(o_rreq && rreq_prev))
      else fail_now("o_rreq stayed high for more than one cycle");
    assert (!(o_wvalid && wvalid_prev))
      else fail_now("o_wvalid stayed high for more than one cycle");
    if (o_wvalid) begin
      tx_q.push_back(o_wdata);
    end
    rreq_prev   = o_rreq;
    wvalid_prev = o_wvalid;
  end

  // random tx fifo room while back-pressure is on
  always begin
    @(posedge i_clk);
    bp_now = bp_enable;
    #1;
    if (bp_now) begin
      bp_rand  = $random(seed);
      i_wready = bp_rand[0] | bp_rand[1];
    end else begin
      i_wready = 1'b1;
    end
  end

  //////////////////////////////
  // stimulus and reference
  //////////////////////////////
  task automatic make_frame(input logic [7:0] msg_type);
    logic [31:0] r;
    int          plen;
    int          i;
    r = $random(seed);
    cur_src = r[15:0];
    cur_dst = r[31:16];
    r = $random(seed);
    plen = 4 + int'(r[3:0]);
    frame_len = 7 + plen;
    frame_bytes[0] = cur_src[15:8];
    frame_bytes[1] = cur_src[7:0];
    frame_bytes[2] = cur_dst[15:8];
    frame_bytes[3] = cur_dst[7:0];
    frame_bytes[4] = 8'h00;
    frame_bytes[5] = 8'(frame_len);
    frame_bytes[6] = msg_type;
    for (i = 7; i < frame_len; i++) begin
      r = $random(seed);
      frame_bytes[i] = r[7:0];
    end
  endtask

  // rx fifo model with the byte one cycle after each rreq pulse
  task automatic offer_frame();
    int   idx;
    int   guard;
    logic pending;
    idx      = 0;
    guard    = 0;
    pending  = 1'b0;
    i_rready = (frame_len > 0);
    while (idx < frame_len) begin
      @(posedge i_clk);
      #1;
      if (pending) begin
        i_rdata  = frame_bytes[idx];
        idx      = idx + 1;
        pending  = 1'b0;
        i_rready = (idx < frame_len);
      end
      if (o_rreq) begin
        pending = 1'b1;
      end
      guard = guard + 1;
      if (guard > 2000) begin
        fail_now("timeout while the DUT drained the receive FIFO");
      end
    end
  endtask

  task automatic compute_expected(input logic is_grant);
    int          tlen;
    int          i;
    logic [15:0] sum;
    tlen = is_grant ? 9 : 8;
    for (i = 0; i < 50; i++) begin
      exp_bytes[i] = 8'h00;
    end
    for (i = 0; i < tlen; i++) begin
      exp_bytes[i] = is_grant ? grant_tmpl[i] : ping_tmpl[i];
    end
    // destination first since the reply goes back
    exp_bytes[0] = cur_dst[15:8];
    exp_bytes[1] = cur_dst[7:0];
    exp_bytes[2] = cur_src[15:8];
    exp_bytes[3] = cur_src[7:0];
    sum = 16'h0000;
    for (i = 0; i < tlen; i++) begin
      sum = sum + {8'h00, exp_bytes[i]};
    end
    exp_bytes[tlen]     = sum[15:8];
    exp_bytes[tlen + 1] = sum[7:0];
  endtask

  task automatic await_reply(input string name);
    int waited;
    int i;
    waited = 0;
    while (tx_q.size() < 50) begin
      @(posedge i_clk);
      #1;
      waited = waited + 1;
      if (waited > 6000) begin
        fail_now($sformatf("timeout waiting for the %s reply", name));
      end
    end
    // nothing may follow the fiftieth byte
    repeat (100) @(posedge i_clk);
    #1;
    assert (tx_q.size() == 50)
      else fail_now($sformatf("MISMATCH %s reply length expected 50 actual %0d",
                              name, tx_q.size()));
    for (i = 0; i < 50; i++) begin
      assert (tx_q[i] === exp_bytes[i])
        else fail_now($sformatf("MISMATCH %s byte %0d expected 0x%02h actual 0x%02h",
                                name, i, exp_bytes[i], tx_q[i]));
    end
    tx_q.delete();
  endtask

  task automatic check_quiet(input string name, input int cycles);
    int n;
    for (n = 0; n < cycles; n++) begin
      @(posedge i_clk);
      #1;
      assert (tx_q.size() == 0)
        else fail_now($sformatf("%s produced a reply byte", name));
    end
  endtask

  task automatic run_request(input string name, input logic [7:0] msg_type,
                             input logic is_grant);
    make_frame(msg_type);
    compute_expected(is_grant);
    offer_frame();
    await_reply(name);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    seed     = 32'h69ff9449;
    i_rst    = 1'b1;
    i_rdata  = 8'h00;
    i_rready = 1'b0;
    repeat (8) @(posedge i_clk);
    #1;
    i_rst = 1'b0;

    // idle with no frame offered
    repeat (100) begin
      @(posedge i_clk);
      #1;
      assert (!o_rreq && !o_wvalid)
        else fail_now("o_rreq or o_wvalid went high with no frame offered");
    end

    run_request("ping", 8'h01, 1'b0);
    run_request("grant", 8'h04, 1'b1);

    // acknowledge and unknown command get no reply
    make_frame(8'h11);
    offer_frame();
    check_quiet("ack type 0x11", 300);
    make_frame(8'h07);
    offer_frame();
    check_quiet("unknown type 0x07", 300);
    run_request("ping after ignored", 8'h01, 1'b0);

    make_frame(8'h04);
    compute_expected(1'b1);
    bp_enable = 1'b1;
    offer_frame();
    await_reply("grant with back-pressure");
    bp_enable = 1'b0;

    $display("Testbench passed");
    $finish;
  end

endmodule

/* verilog.f */
rtl/mhp_pkg.sv
rtl/ram_if.sv
rtl/frame_ram.sv
rtl/frame_receiver.sv
rtl/header_reader.sv
rtl/reply_builder.sv
rtl/checksum_unit.sv
rtl/frame_sender.sv
rtl/message_controller.sv
rtl/mhp_top.sv
tests/tb_mhp.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mhp -f verilog.f -o tb_mhp
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tb_mhp
if [ $? -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi
exit 0
